/* axil_seq_macros.svh */
// AXI4-Lite command sequencer sizes
// Table depth and bus widths, shared by the package and the RTL
`ifndef AXIL_SEQ_MACROS_SVH
`define AXIL_SEQ_MACROS_SVH

`default_nettype none

// Number of command table entries, also the result store depth
`define AXIL_SEQ_NUM_CMDS 16

// AXI4-Lite bus widths
`define AXIL_SEQ_ADDR_W 32
`define AXIL_SEQ_DATA_W 32

`default_nettype wire

`endif

/* axil_seq_pkg.sv */
// AXI4-Lite command sequencer package
// Vector types for addresses, data and indices, plus the command
// kind and sequencer state encodings
`include "axil_seq_macros.svh"

`default_nettype none

package axil_seq_pkg;

    localparam int unsigned CMD_INDEX_W = $clog2(`AXIL_SEQ_NUM_CMDS);

    typedef logic [`AXIL_SEQ_ADDR_W-1:0] axil_addr_t;
    typedef logic [`AXIL_SEQ_DATA_W-1:0] axil_data_t;
    typedef logic [CMD_INDEX_W-1:0]      cmd_index_t;
    typedef logic [1:0]                  axil_resp_t;

    // Command kinds held in the table
    typedef enum logic [1:0] {
        cmd_write     = 2'd0,
        cmd_read      = 2'd1,
        cmd_poll      = 2'd2,
        cmd_write_irq = 2'd3
    } cmd_kind_t;

    typedef enum logic [2:0] {
        seq_idle,
        seq_issue,
        seq_wait_resp,
        seq_wait_irq,
        seq_next,
        seq_done
    } seq_state_t;

endpackage

`default_nettype wire

/* cmd_if.sv */
// Command table lookup interface
// The sequencer presents an index, the table answers with that entry
// in the same cycle
`default_nettype none

interface cmd_if;

    axil_seq_pkg::cmd_index_t index;
    axil_seq_pkg::cmd_kind_t  kind;
    axil_seq_pkg::axil_addr_t addr;
    axil_seq_pkg::axil_data_t wdata;
    axil_seq_pkg::axil_data_t mask;
    axil_seq_pkg::axil_data_t match;
    logic                     last;

    modport seq (output index, input kind, addr, wdata, mask, match, last);

    modport tbl (input index, output kind, addr, wdata, mask, match, last);

endinterface

`default_nettype wire

/* cmd_table.sv */
// Command table
// Holds the command list loaded by the host, one whole entry per
// load cycle, and returns the entry selected by the sequencer
`include "axil_seq_macros.svh"

`default_nettype none

module cmd_table (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     cmd_we,
    input  axil_seq_pkg::cmd_index_t cmd_index,
    input  axil_seq_pkg::cmd_kind_t  cmd_kind,
    input  axil_seq_pkg::axil_addr_t cmd_addr,
    input  axil_seq_pkg::axil_data_t cmd_wdata,
    input  axil_seq_pkg::axil_data_t cmd_mask,
    input  axil_seq_pkg::axil_data_t cmd_match,
    input  logic                     cmd_last,
    cmd_if.tbl                       cmd
);
    import axil_seq_pkg::*;

    cmd_kind_t  kind_mem  [`AXIL_SEQ_NUM_CMDS];
    axil_addr_t addr_mem  [`AXIL_SEQ_NUM_CMDS];
    axil_data_t wdata_mem [`AXIL_SEQ_NUM_CMDS];
    axil_data_t mask_mem  [`AXIL_SEQ_NUM_CMDS];
    axil_data_t match_mem [`AXIL_SEQ_NUM_CMDS];
    logic [`AXIL_SEQ_NUM_CMDS-1:0] last_mem;

    // Last flags start cleared so a stale table cannot end a run early
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            last_mem <= '0;
        end else if (cmd_we) begin
            last_mem[cmd_index] <= cmd_last;
        end
    end

    always_ff @(posedge clock) begin
        if (cmd_we) begin
            kind_mem[cmd_index]  <= cmd_kind;
            addr_mem[cmd_index]  <= cmd_addr;
            wdata_mem[cmd_index] <= cmd_wdata;
            mask_mem[cmd_index]  <= cmd_mask;
            match_mem[cmd_index] <= cmd_match;
        end
    end

    // Combinational lookup
    assign cmd.kind  = kind_mem[cmd.index];
    assign cmd.addr  = addr_mem[cmd.index];
    assign cmd.wdata = wdata_mem[cmd.index];
    assign cmd.mask  = mask_mem[cmd.index];
    assign cmd.match = match_mem[cmd.index];
    assign cmd.last  = last_mem[cmd.index];

endmodule

`default_nettype wire

/* axil_cmd_seq.sv */
// AXI4-Lite command sequencer
// Walks the command table from entry 0 to the last entry, issuing one
// AXI4-Lite transaction at a time. Polls retry until the masked data
// matches, write_irq entries wait for irq, read data goes to the
// result store and any non-OKAY response sets a sticky error flag
`include "axil_seq_macros.svh"

`default_nettype none

module axil_cmd_seq (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     start,
    output logic                     busy,
    output logic                     done,
    output logic                     error,
    input  logic                     irq,
    cmd_if.seq                       cmd,
    output logic                     res_we,
    output axil_seq_pkg::cmd_index_t res_index,
    output axil_seq_pkg::axil_data_t res_data,
    output logic                     awvalid,
    input  logic                     awready,
    output axil_seq_pkg::axil_addr_t awaddr,
    output logic                     wvalid,
    input  logic                     wready,
    output axil_seq_pkg::axil_data_t wdata,
    input  logic                     bvalid,
    output logic                     bready,
    input  axil_seq_pkg::axil_resp_t bresp,
    output logic                     arvalid,
    input  logic                     arready,
    output axil_seq_pkg::axil_addr_t araddr,
    input  logic                     rvalid,
    output logic                     rready,
    input  axil_seq_pkg::axil_data_t rdata,
    input  axil_seq_pkg::axil_resp_t rresp
);
    import axil_seq_pkg::*;

    localparam axil_resp_t RESP_OKAY = 2'b00;

    seq_state_t state;
    cmd_index_t index;
    logic       aw_done;
    logic       w_done;
    logic       aw_hs;
    logic       w_hs;
    logic       b_hs;
    logic       ar_hs;
    logic       r_hs;
    logic       is_write;
    logic       poll_hit;
    logic       last_entry;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;
    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    assign is_write   = (cmd.kind == cmd_write) || (cmd.kind == cmd_write_irq);
    assign poll_hit   = (rdata & cmd.mask) == (cmd.match & cmd.mask);
    // A full table ends the run even without a last flag
    assign last_entry = cmd.last || (index == cmd_index_t'(`AXIL_SEQ_NUM_CMDS - 1));

    assign cmd.index = index;
    assign res_index = index;
    assign bready    = 1'b1;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= seq_idle;
            index   <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
            error   <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            res_we  <= 1'b0;
        end else begin
            done   <= 1'b0;
            res_we <= 1'b0;
            case (state)
                seq_idle: begin
                    if (start) begin
                        busy  <= 1'b1;
                        error <= 1'b0;
                        index <= '0;
                        state <= seq_issue;
                    end
                end
                seq_issue: begin
                    if (is_write) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end else begin
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                    end
                    state <= seq_wait_resp;
                end
                seq_wait_resp: begin
                    if (is_write) begin
                        // AW and W complete independently, B only after both
                        if (aw_hs) begin
                            awvalid <= 1'b0;
                            aw_done <= 1'b1;
                        end
                        if (w_hs) begin
                            wvalid <= 1'b0;
                            w_done <= 1'b1;
                        end
                        if (aw_done && w_done && b_hs) begin
                            if (bresp != RESP_OKAY) begin
                                error <= 1'b1;
                            end
                            state <= (cmd.kind == cmd_write_irq) ? seq_wait_irq : seq_next;
                        end
                    end else begin
                        if (ar_hs) begin
                            arvalid <= 1'b0;
                        end
                        if (r_hs) begin
                            rready <= 1'b0;
                            if (rresp != RESP_OKAY) begin
                                error <= 1'b1;
                            end
                            if (cmd.kind == cmd_poll && !poll_hit) begin
                                // Poll miss, read the same address again
                                arvalid <= 1'b1;
                                rready  <= 1'b1;
                            end else begin
                                res_we <= 1'b1;
                                state  <= seq_next;
                            end
                        end
                    end
                end
                seq_wait_irq: begin
                    if (irq) begin
                        state <= seq_next;
                    end
                end
                seq_next: begin
                    if (last_entry) begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= seq_done;
                    end else begin
                        index <= index + 1'b1;
                        state <= seq_issue;
                    end
                end
                seq_done: begin
                    state <= seq_idle;
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

    // Address and data payloads, loaded as each entry is issued
    always_ff @(posedge clock) begin
        if (state == seq_issue) begin
            awaddr <= cmd.addr;
            wdata  <= cmd.wdata;
            araddr <= cmd.addr;
        end
        if (r_hs) begin
            res_data <= rdata;
        end
    end

endmodule

`default_nettype wire

/* result_store.sv */
// Result store
// One data word per command position, written by the sequencer and
// read back by the host through a registered port
`include "axil_seq_macros.svh"

`default_nettype none

module result_store (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     res_we,
    input  axil_seq_pkg::cmd_index_t res_index,
    input  axil_seq_pkg::axil_data_t res_data,
    input  axil_seq_pkg::cmd_index_t res_rd_index,
    output axil_seq_pkg::axil_data_t res_rdata
);
    import axil_seq_pkg::*;

    axil_data_t mem [`AXIL_SEQ_NUM_CMDS];

    always_ff @(posedge clock) begin
        if (res_we) begin
            mem[res_index] <= res_data;
        end
    end

    // Host read, one cycle latency
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            res_rdata <= '0;
        end else begin
            res_rdata <= mem[res_rd_index];
        end
    end

endmodule

`default_nettype wire

/* axil_seq_top.sv */
// AXI4-Lite command sequencer top level
// Command table feeding the sequencer, which drives the AXI4-Lite
// master port and fills the result store
`default_nettype none

module axil_seq_top (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     cmd_we,
    input  axil_seq_pkg::cmd_index_t cmd_index,
    input  axil_seq_pkg::cmd_kind_t  cmd_kind,
    input  axil_seq_pkg::axil_addr_t cmd_addr,
    input  axil_seq_pkg::axil_data_t cmd_wdata,
    input  axil_seq_pkg::axil_data_t cmd_mask,
    input  axil_seq_pkg::axil_data_t cmd_match,
    input  logic                     cmd_last,
    input  logic                     start,
    output logic                     busy,
    output logic                     done,
    output logic                     error,
    input  logic                     irq,
    input  axil_seq_pkg::cmd_index_t res_rd_index,
    output axil_seq_pkg::axil_data_t res_rdata,
    output logic                     awvalid,
    input  logic                     awready,
    output axil_seq_pkg::axil_addr_t awaddr,
    output logic                     wvalid,
    input  logic                     wready,
    output axil_seq_pkg::axil_data_t wdata,
    input  logic                     bvalid,
    output logic                     bready,
    input  axil_seq_pkg::axil_resp_t bresp,
    output logic                     arvalid,
    input  logic                     arready,
    output axil_seq_pkg::axil_addr_t araddr,
    input  logic                     rvalid,
    output logic                     rready,
    input  axil_seq_pkg::axil_data_t rdata,
    input  axil_seq_pkg::axil_resp_t rresp
);
    import axil_seq_pkg::*;

    // Sequencer to result store
    logic       res_we;
    cmd_index_t res_index;
    axil_data_t res_data;

    // Entry lookup between table and sequencer
    cmd_if cmd ();

    cmd_table i_cmd_table (.*);

    axil_cmd_seq i_axil_cmd_seq (.*);

    result_store i_result_store (.*);

endmodule

`default_nettype wire

/* axil_slave_model.sv */
// AXI4-Lite slave model for the sequencer testbench
// 64 word register file with a preloaded pattern, a counting poll
// register, an address that answers SLVERR, and random ready delays
`default_nettype none

module axil_slave_model (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     awvalid,
    output logic                     awready,
    input  axil_seq_pkg::axil_addr_t awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  axil_seq_pkg::axil_data_t wdata,
    output logic                     bvalid,
    input  logic                     bready,
    output axil_seq_pkg::axil_resp_t bresp,
    input  logic                     arvalid,
    output logic                     arready,
    input  axil_seq_pkg::axil_addr_t araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output axil_seq_pkg::axil_data_t rdata,
    output axil_seq_pkg::axil_resp_t rresp
);
    timeunit 1ns;
    timeprecision 1ps;
    import axil_seq_pkg::*;

    localparam axil_addr_t POLL_ADDR = 32'h0000_0080;
    localparam axil_addr_t ERR_ADDR  = 32'h0000_00fc;
    localparam axil_resp_t SLVERR    = 2'b10;

    axil_data_t  mem [64];
    axil_data_t  poll_count;
    axil_addr_t  wr_addr;
    axil_data_t  wr_data;
    axil_addr_t  rd_addr;
    logic        aw_got;
    logic        w_got;
    logic        ar_got;
    int unsigned aw_wait;
    int unsigned w_wait;
    int unsigned ar_wait;

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // Preload pattern built from the full word index
            for (int i = 0; i < 64; i++) begin
                mem[i] <= {16'h5eed, 2'b00, 6'(i), 2'b00, ~6'(i)};
            end
            poll_count <= '0;
            awready    <= 1'b0;
            wready     <= 1'b0;
            arready    <= 1'b0;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            bresp      <= '0;
            rresp      <= '0;
            rdata      <= '0;
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            ar_got     <= 1'b0;
            aw_wait    <= 0;
            w_wait     <= 0;
            ar_wait    <= 0;
        end else begin
            // Ready pulses last one cycle
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;

            if (awvalid && !awready && !aw_got) begin
                if (aw_wait == 0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 1;
                end
            end
            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                wr_addr <= awaddr;
                aw_wait <= $urandom % 4;
            end

            if (wvalid && !wready && !w_got) begin
                if (w_wait == 0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 1;
                end
            end
            if (wvalid && wready) begin
                w_got   <= 1'b1;
                wr_data <= wdata;
                w_wait  <= $urandom % 4;
            end

            // Write response once both address and data are in
            if (aw_got && w_got && !bvalid) begin
                bvalid <= 1'b1;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                if (wr_addr == ERR_ADDR) begin
                    bresp <= SLVERR;
                end else begin
                    bresp <= '0;
                    if (wr_addr == POLL_ADDR) begin
                        poll_count <= wr_data;
                    end else begin
                        mem[wr_addr[7:2]] <= wr_data;
                    end
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (arvalid && !arready && !ar_got) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end
            if (arvalid && arready) begin
                ar_got  <= 1'b1;
                rd_addr <= araddr;
                ar_wait <= $urandom % 4;
            end

            if (ar_got && !rvalid) begin
                rvalid <= 1'b1;
                ar_got <= 1'b0;
                if (rd_addr == ERR_ADDR) begin
                    rdata <= '0;
                    rresp <= SLVERR;
                end else if (rd_addr == POLL_ADDR) begin
                    // Counter advances on every read
                    rdata      <= poll_count;
                    poll_count <= poll_count + 1;
                    rresp      <= '0;
                end else begin
                    rdata <= mem[rd_addr[7:2]];
                    rresp <= '0;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* axil_seq_assert.sv */
// AXI4-Lite handshake assertions for the command sequencer
// Valid must hold until its transfer, payloads stay stable while
// stalled, and no read is issued while a write is still open
`default_nettype none

module axil_seq_assert (
    input logic                     clock,
    input logic                     rst_n,
    input logic                     awvalid,
    input logic                     awready,
    input axil_seq_pkg::axil_addr_t awaddr,
    input logic                     wvalid,
    input logic                     wready,
    input axil_seq_pkg::axil_data_t wdata,
    input logic                     bvalid,
    input logic                     bready,
    input logic                     arvalid,
    input logic                     arready,
    input axil_seq_pkg::axil_addr_t araddr
);
    timeunit 1ns;
    timeprecision 1ps;

    logic write_open;

    // Open from the first AW or W valid until the B transfer
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            write_open <= 1'b0;
        end else if (bvalid && bready) begin
            write_open <= 1'b0;
        end else if (awvalid || wvalid) begin
            write_open <= 1'b1;
        end
    end

    aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr changed before the AW transfer");

    w_hold: assert property (@(posedge clock) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wvalid dropped or wdata changed before the W transfer");

    ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr changed before the AR transfer");

    no_overlap: assert property (@(posedge clock) disable iff (!rst_n)
        !(arvalid && (awvalid || wvalid || write_open)))
        else $error("arvalid raised while a write is outstanding");

endmodule

`default_nettype wire

/* tb_axil_seq.sv */
// Testbench for the AXI4-Lite command sequencer
// Loads a command list, runs it twice against the slave model and
// checks the result store, the model memory, the error flag and irq
`default_nettype none

module tb_axil_seq;
    timeunit 1ns;
    timeprecision 1ps;
    import axil_seq_pkg::*;

    localparam int         NUM_ENTRIES = 11;
    localparam int         WAIT_LIMIT  = 5000;
    localparam axil_addr_t POLL_ADDR   = 32'h0000_0080;
    localparam axil_addr_t ERR_ADDR    = 32'h0000_00fc;

    logic       clock;
    logic       rst_n;
    logic       cmd_we;
    cmd_index_t cmd_index;
    cmd_kind_t  cmd_kind;
    axil_addr_t cmd_addr;
    axil_data_t cmd_wdata;
    axil_data_t cmd_mask;
    axil_data_t cmd_match;
    logic       cmd_last;
    logic       start;
    logic       busy;
    logic       done;
    logic       error;
    logic       irq;
    cmd_index_t res_rd_index;
    axil_data_t res_rdata;
    logic       awvalid;
    logic       awready;
    axil_addr_t awaddr;
    logic       wvalid;
    logic       wready;
    axil_data_t wdata;
    logic       bvalid;
    logic       bready;
    axil_resp_t bresp;
    logic       arvalid;
    logic       arready;
    axil_addr_t araddr;
    logic       rvalid;
    logic       rready;
    axil_data_t rdata;
    axil_resp_t rresp;

    // Command list with expected results
    cmd_kind_t   tab_kind   [NUM_ENTRIES];
    axil_addr_t  tab_addr   [NUM_ENTRIES];
    axil_data_t  tab_wdata  [NUM_ENTRIES];
    axil_data_t  tab_mask   [NUM_ENTRIES];
    axil_data_t  tab_match  [NUM_ENTRIES];
    logic        tab_check  [NUM_ENTRIES];
    axil_data_t  tab_expect [NUM_ENTRIES];
    axil_data_t  first_run  [NUM_ENTRIES];
    int          error_count;
    int          timeout_count;

    axil_seq_top i_axil_seq_top (.*);

    axil_slave_model i_axil_slave_model (.*);

    bind axil_cmd_seq axil_seq_assert i_axil_seq_assert (.*);

    always #50 clock = ~clock;

    // Register preload as seen at a given address
    function automatic axil_data_t preload_value(input axil_addr_t addr);
        logic [5:0] word;
        word = addr[7:2];
        return {16'h5eed, 2'b00, word, 2'b00, ~word};
    endfunction

    // First counter value at or after from whose masked bits match
    function automatic axil_data_t poll_result(input axil_data_t from, input axil_data_t mask,
                                               input axil_data_t match);
        axil_data_t value;
        value = from;
        for (int i = 0; i < 1024; i++) begin
            if ((value & mask) == (match & mask)) begin
                break;
            end
            value = value + 1;
        end
        return value;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic report_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        error_count++;
    endtask

    // Outputs held by reset
    task automatic check_reset_values();
        if (busy !== 1'b0 || done !== 1'b0 || error !== 1'b0) begin
            report_error($sformatf("busy %b done %b error %b in reset", busy, done, error));
        end
        if (awvalid !== 1'b0 || wvalid !== 1'b0 || arvalid !== 1'b0 || rready !== 1'b0) begin
            report_error($sformatf("awvalid %b wvalid %b arvalid %b rready %b in reset",
                                   awvalid, wvalid, arvalid, rready));
        end
        if (bready !== 1'b1) begin
            report_error($sformatf("bready %b in reset", bready));
        end
    endtask

    task automatic set_entry(input int i, input cmd_kind_t kind, input axil_addr_t addr,
                             input axil_data_t wdat, input axil_data_t mask,
                             input axil_data_t match, input logic check,
                             input axil_data_t exp_value);
        tab_kind[i]   = kind;
        tab_addr[i]   = addr;
        tab_wdata[i]  = wdat;
        tab_mask[i]   = mask;
        tab_match[i]  = match;
        tab_check[i]  = check;
        tab_expect[i] = exp_value;
    endtask

    task automatic fill_table();
        set_entry(0, cmd_write, 32'h10, 32'h1234_5678, '0, '0, 1'b0, '0);
        set_entry(1, cmd_write, 32'h14, 32'hcafe_f00d, '0, '0, 1'b0, '0);
        set_entry(2, cmd_read, 32'h10, '0, '0, '0, 1'b1, 32'h1234_5678);
        set_entry(3, cmd_read, 32'h14, '0, '0, '0, 1'b1, 32'hcafe_f00d);
        set_entry(4, cmd_read, 32'h40, '0, '0, '0, 1'b1, preload_value(32'h40));
        set_entry(5, cmd_read, 32'hc4, '0, '0, '0, 1'b1, preload_value(32'hc4));
        // Restart the counter so both runs poll the same values
        set_entry(6, cmd_write, POLL_ADDR, 32'h0000_0100, '0, '0, 1'b0, '0);
        set_entry(7, cmd_poll, POLL_ADDR, '0, 32'h0000_00ff, 32'h5, 1'b1,
                  poll_result(32'h0000_0100, 32'h0000_00ff, 32'h5));
        // Error address answers SLVERR with zero data
        set_entry(8, cmd_read, ERR_ADDR, '0, '0, '0, 1'b1, '0);
        set_entry(9, cmd_read, 32'h20, '0, '0, '0, 1'b1, preload_value(32'h20));
        set_entry(10, cmd_write_irq, 32'h18, 32'h0bad_cafe, '0, '0, 1'b0, '0);
    endtask

    task automatic load_table();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            cmd_we    = 1'b1;
            cmd_index = cmd_index_t'(i);
            cmd_kind  = tab_kind[i];
            cmd_addr  = tab_addr[i];
            cmd_wdata = tab_wdata[i];
            cmd_mask  = tab_mask[i];
            cmd_match = tab_match[i];
            cmd_last  = (i == NUM_ENTRIES - 1);
            next_cycle();
        end
        cmd_we   = 1'b0;
        cmd_last = 1'b0;
    endtask

    task automatic run_sequence(input int run);
        int n;
        int hold;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        if (busy !== 1'b1) begin
            report_error($sformatf("busy not high after start in run %0d", run));
        end
        if (error !== 1'b0) begin
            report_error($sformatf("error flag not cleared by start in run %0d", run));
        end
        n = 0;
        while (i_axil_seq_top.i_axil_cmd_seq.state != seq_wait_irq && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("Timed out waiting for the interrupt wait in run %0d", run);
            timeout_count++;
        end else begin
            // Hold irq low, the sequence must stay busy
            hold = 20 + ($urandom % 41);
            repeat (hold) begin
                next_cycle();
                if (busy !== 1'b1 || done !== 1'b0) begin
                    report_error($sformatf("busy %b done %b while irq low", busy, done));
                end
            end
            irq = 1'b1;
            n = 0;
            while (done !== 1'b1 && n < WAIT_LIMIT) begin
                next_cycle();
                n++;
            end
            if (n >= WAIT_LIMIT) begin
                $display("Timed out waiting for done in run %0d", run);
                timeout_count++;
            end else begin
                if (error !== 1'b1) begin
                    report_error($sformatf("error flag low at done in run %0d", run));
                end
                if (busy !== 1'b0) begin
                    report_error($sformatf("busy still high at done in run %0d", run));
                end
            end
            irq = 1'b0;
        end
    endtask

    task automatic read_results(input int run);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (tab_check[i]) begin
                res_rd_index = cmd_index_t'(i);
                next_cycle();
                if (res_rdata !== tab_expect[i]) begin
                    report_error($sformatf("run %0d entry %0d result %h, expected %h",
                                           run, i, res_rdata, tab_expect[i]));
                end
                if (run == 1) begin
                    first_run[i] = res_rdata;
                end else if (res_rdata !== first_run[i]) begin
                    report_error($sformatf("entry %0d result %h differs from first run %h",
                                           i, res_rdata, first_run[i]));
                end
            end
        end
    endtask

    task automatic check_model_memory();
        axil_data_t stored;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if ((tab_kind[i] == cmd_write || tab_kind[i] == cmd_write_irq) &&
                tab_addr[i] != POLL_ADDR && tab_addr[i] != ERR_ADDR) begin
                stored = i_axil_slave_model.mem[tab_addr[i][7:2]];
                if (stored !== tab_wdata[i]) begin
                    report_error($sformatf("model word at %h is %h, expected %h",
                                           tab_addr[i], stored, tab_wdata[i]));
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'he927));
        error_count   = 0;
        timeout_count = 0;
        clock         = 1'b0;
        rst_n         = 1'b0;
        cmd_we        = 1'b0;
        cmd_index     = '0;
        cmd_kind      = cmd_write;
        cmd_addr      = '0;
        cmd_wdata     = '0;
        cmd_mask      = '0;
        cmd_match     = '0;
        cmd_last      = 1'b0;
        start         = 1'b0;
        irq           = 1'b0;
        res_rd_index  = '0;
        fill_table();
        repeat (16) @(posedge clock);
        #1;
        check_reset_values();
        rst_n = 1'b1;
        next_cycle();
        load_table();
        run_sequence(1);
        read_results(1);
        check_model_memory();
        // Second pass sees different ready delays
        run_sequence(2);
        read_results(2);
        check_model_memory();
        $display("Summary: %0d check errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
axil_seq_pkg.sv
cmd_if.sv
cmd_table.sv
axil_cmd_seq.sv
result_store.sv
axil_seq_top.sv
axil_slave_model.sv
axil_seq_assert.sv
tb_axil_seq.sv

/* Bender.yml */
package:
  name: axil_seq

sources:
  - include_dirs:
      - .
    files:
      - axil_seq_pkg.sv
      - cmd_if.sv
      - cmd_table.sv
      - axil_cmd_seq.sv
      - result_store.sv
      - axil_seq_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - axil_slave_model.sv
      - axil_seq_assert.sv
      - tb_axil_seq.sv
